// File: sim.f
+incdir+include
source/soc_bus_pkg.sv
source/board_io_pkg.sv
source/rst_conditioner.sv
source/heartbeat_gen.sv
source/axil_slave_port.sv
source/bus_interconnect.sv
source/boot_ram.sv
source/board_pio.sv
source/board_top.sv
tests/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_board_top -f sim.f -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_board_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: tests/tb_board_top.sv
/*
 * Directed testbench for board_top with clock, reset, AXI4-Lite
 * tasks, tests, watchdog and summary
 */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module tb_board_top import soc_bus_pkg::*, board_io_pkg::*;;

    localparam int handshake_limit = 100;
    // Reset and per-test budgets in ns add up to the watchdog limit
    localparam int watchdog_ns = 1000 + 4000 + 4000 + 2000 + 2000 + 3000 + 4000;
    localparam logic [31:0] pio = `BRD_PIO_BASE;

    logic         cpu_clk;
    logic         hard_rst_n;
    logic         key_rst_n_i;
    logic [9:0]   sw_i;
    axil_req_t    axil_req;
    axil_rsp_t    axil_rsp;
    board_leds_t  ledr;
    hex_display_t hex;

    int    errors;
    int    errs_at_start;
    int    tests_run;
    int    tests_failed;
    string cur_test;

    board_top dut0 (
        .cpu_clk     (cpu_clk),
        .hard_rst_n  (hard_rst_n),
        .key_rst_n_i (key_rst_n_i),
        .sw_i        (sw_i),
        .axil_req_i  (axil_req),
        .axil_rsp_o  (axil_rsp),
        .ledr_o      (ledr),
        .hex_o       (hex)
    );

    always #2 cpu_clk = ~cpu_clk;

    // ====================
    // Helpers
    // ====================
    task automatic next_cycle();
        @(posedge cpu_clk);
        #1;
    endtask

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
    endtask

    task automatic report_test();
        tests_run++;
        if (errors == errs_at_start) begin
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d checks failed", cur_test, errors - errs_at_start);
        end
    endtask

    // Expected RAM word after a strobed write
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int n;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        n = 0;
        while (!(axil_rsp.awready && axil_rsp.wready) && n < handshake_limit) begin
            next_cycle();
            n++;
        end
        if (n == handshake_limit) begin
            $display("write to %h was never accepted", addr);
            errors++;
        end
        next_cycle();
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        n = 0;
        while (!axil_rsp.bvalid && n < handshake_limit) begin
            next_cycle();
            n++;
        end
        if (n == handshake_limit) begin
            $display("write to %h never got a write response", addr);
            errors++;
        end
        resp = axil_rsp.bresp;
        next_cycle();
        axil_req.bready = 1'b0;
    endtask

    // Keeps rready low for stall cycles once rvalid is up
    task automatic axil_read(input logic [31:0] addr, input int stall,
                             output logic [1:0] resp, output logic [31:0] data,
                             output bit stable);
        int n;
        stable           = 1'b1;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        n = 0;
        while (!axil_rsp.arready && n < handshake_limit) begin
            next_cycle();
            n++;
        end
        if (n == handshake_limit) begin
            $display("read from %h was never accepted", addr);
            errors++;
        end
        next_cycle();
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid && n < handshake_limit) begin
            next_cycle();
            n++;
        end
        if (n == handshake_limit) begin
            $display("read from %h never returned data", addr);
            errors++;
        end
        resp = axil_rsp.rresp;
        data = axil_rsp.rdata;
        for (int i = 0; i < stall; i++) begin
            next_cycle();
            if (!axil_rsp.rvalid || axil_rsp.rdata !== data) stable = 1'b0;
        end
        axil_req.rready = 1'b1;
        next_cycle();
        axil_req.rready = 1'b0;
    endtask

    task automatic wait_reset_state(input logic level, input int bound, output bit ok);
        int n;
        n = 0;
        while (ledr.in_reset !== level && n < bound) begin
            next_cycle();
            n++;
        end
        ok = (ledr.in_reset === level);
    endtask

    // ====================
    // Tests
    // ====================
    task automatic ram_byte_lanes();
        localparam logic [15:0] lane_masks = 16'b0110_1010_0100_0001;
        logic [31:0] shadow [4];
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  resp;
        bit          stable;
        start_test("ram_byte_lanes");
        for (int i = 0; i < 4; i++) begin
            addr      = `BRD_RAM_BASE + 32'(i * 12);
            shadow[i] = $urandom;
            axil_write(addr, shadow[i], 4'hF, resp);
            compare_word("full write bresp", {30'd0, resp_okay}, {30'd0, resp});
        end
        for (int i = 0; i < 4; i++) begin
            addr      = `BRD_RAM_BASE + 32'(i * 12);
            data      = $urandom;
            shadow[i] = merge_lanes(shadow[i], data, lane_masks[4*i +: 4]);
            axil_write(addr, data, lane_masks[4*i +: 4], resp);
            compare_word("partial write bresp", {30'd0, resp_okay}, {30'd0, resp});
        end
        for (int i = 0; i < 4; i++) begin
            addr = `BRD_RAM_BASE + 32'(i * 12);
            axil_read(addr, 0, resp, data, stable);
            compare_word("rresp", {30'd0, resp_okay}, {30'd0, resp});
            compare_word("rdata", shadow[i], data);
        end
        report_test();
    endtask

    task automatic pio_registers();
        logic [31:0] val;
        logic [31:0] data;
        logic [15:0] shown;
        logic [1:0]  resp;
        bit          stable;
        start_test("pio_registers");
        val = $urandom;
        axil_write(pio, val, 4'hF, resp);
        compare_word("LED bresp", {30'd0, resp_okay}, {30'd0, resp});
        compare_word("user LEDs", {24'd0, val[7:0]}, {24'd0, ledr.user});
        axil_read(pio, 0, resp, data, stable);
        compare_word("LED readback", {24'd0, val[7:0]}, data);
        for (int k = 1; k < 4; k++) begin
            val = $urandom;
            axil_write(pio + 32'(4 * k), val, 4'hF, resp);
            compare_word("HEX bresp", {30'd0, resp_okay}, {30'd0, resp});
            case (k)
                1:       shown = {hex.hex1, hex.hex0};
                2:       shown = {hex.hex3, hex.hex2};
                default: shown = {hex.hex5, hex.hex4};
            endcase
            compare_word("HEX digits", {16'd0, val[15:0]}, {16'd0, shown});
            axil_read(pio + 32'(4 * k), 0, resp, data, stable);
            compare_word("HEX readback", {16'd0, val[15:0]}, data);
        end
        val  = $urandom;
        sw_i = val[9:0];
        next_cycle();
        axil_read(pio + 32'h10, 0, resp, data, stable);
        compare_word("SW readback", {22'd0, val[9:0]}, data);
        axil_write(pio + 32'h10, $urandom, 4'hF, resp);
        compare_word("SW write bresp", {30'd0, resp_okay}, {30'd0, resp});
        axil_read(pio + 32'h10, 0, resp, data, stable);
        compare_word("SW after write", {22'd0, val[9:0]}, data);
        axil_read(pio + 32'h14, 0, resp, data, stable);
        compare_word("SOC_ID", `BRD_SOC_ID, data);
        axil_read(pio + 32'h18, 0, resp, data, stable);
        compare_word("BLD_ID", `BRD_BLD_ID, data);
        axil_read(pio + 32'h1C, 0, resp, data, stable);
        compare_word("CLK_FREQ", `BRD_CORE_CLK_FREQ, data);
        report_test();
    endtask

    task automatic unmapped_access();
        logic [31:0] holes [2];
        logic [31:0] data;
        logic [1:0]  resp;
        bit          stable;
        start_test("unmapped_access");
        // Just past the RAM, and well past the peripheral window
        holes[0] = `BRD_RAM_BASE + 32'h400;
        holes[1] = 32'h0002_0000;
        for (int i = 0; i < 2; i++) begin
            axil_write(holes[i], $urandom, 4'hF, resp);
            compare_word("bresp", {30'd0, resp_slverr}, {30'd0, resp});
            axil_read(holes[i], 0, resp, data, stable);
            compare_word("rresp", {30'd0, resp_slverr}, {30'd0, resp});
            compare_word("rdata", 32'd0, data);
        end
        report_test();
    endtask

    task automatic read_backpressure();
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] data;
        logic [1:0]  resp;
        bit          stable;
        start_test("read_backpressure");
        word_a = $urandom;
        word_b = $urandom;
        axil_write(`BRD_RAM_BASE + 32'h200, word_a, 4'hF, resp);
        axil_write(`BRD_RAM_BASE + 32'h204, word_b, 4'hF, resp);
        axil_read(`BRD_RAM_BASE + 32'h200, 10, resp, data, stable);
        compare_word("stalled rdata", word_a, data);
        if (!stable) begin
            $display("%s: rvalid or rdata changed while rready was low", cur_test);
            errors++;
        end
        axil_read(`BRD_RAM_BASE + 32'h204, 0, resp, data, stable);
        compare_word("next rdata", word_b, data);
        report_test();
    endtask

    task automatic heartbeat_toggle();
        logic prev;
        int   changes;
        start_test("heartbeat_toggle");
        prev    = ledr.heartbeat;
        changes = 0;
        for (int i = 0; i < 3 * (`BRD_HEARTBEAT_TICKS + 1); i++) begin
            next_cycle();
            if (ledr.heartbeat !== prev) changes++;
            prev = ledr.heartbeat;
        end
        if (changes < 2) begin
            $display("mismatch %s toggles: expected at least 2, actual %0d", cur_test, changes);
            errors++;
        end
        report_test();
    endtask

    task automatic key_reset_cycle();
        logic [31:0] kept;
        logic [31:0] data;
        logic [1:0]  resp;
        bit          ok;
        bit          stable;
        start_test("key_reset_cycle");
        kept = $urandom;
        axil_write(`BRD_RAM_BASE + 32'h300, kept, 4'hF, resp);
        axil_write(pio, 32'hA5, 4'hF, resp);
        axil_write(pio + 32'h4, 32'h1234, 4'hF, resp);
        axil_write(pio + 32'h8, 32'h5678, 4'hF, resp);
        axil_write(pio + 32'hC, 32'h9ABC, 4'hF, resp);
        key_rst_n_i = 1'b0;
        wait_reset_state(1'b1, 8, ok);
        if (!ok) begin
            $display("%s: in_reset did not rise after the key was pressed", cur_test);
            errors++;
        end
        repeat (4) next_cycle();
        key_rst_n_i = 1'b1;
        wait_reset_state(1'b0, `BRD_RST_HOLD_CYCLES + 8, ok);
        if (!ok) begin
            $display("%s: in_reset did not fall after the key was released", cur_test);
            errors++;
        end
        compare_word("user LEDs", 32'd0, {24'd0, ledr.user});
        compare_word("HEX digits low", 32'd0, hex[31:0]);
        compare_word("HEX digits high", 32'd0, {16'd0, hex[47:32]});
        for (int k = 0; k < 4; k++) begin
            axil_read(pio + 32'(4 * k), 0, resp, data, stable);
            compare_word("register after reset", 32'd0, data);
        end
        axil_read(`BRD_RAM_BASE + 32'h300, 0, resp, data, stable);
        compare_word("RAM after reset", kept, data);
        report_test();
    endtask

    // ====================
    // Run
    // ====================
    initial begin
        #(watchdog_ns);
        $display("watchdog: run did not finish within %0d ns", watchdog_ns);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit ok;
        void'($urandom(32'ha9306c7a));
        cpu_clk      = 1'b0;
        hard_rst_n   = 1'b0;
        key_rst_n_i  = 1'b0;
        sw_i         = '0;
        axil_req     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge cpu_clk);
        #1;
        hard_rst_n  = 1'b1;
        key_rst_n_i = 1'b1;
        wait_reset_state(1'b0, `BRD_RST_HOLD_CYCLES + 8, ok);
        if (!ok) begin
            $display("SoC reset did not release after power-up");
            errors++;
        end
        ram_byte_lanes();
        pio_registers();
        unmapped_access();
        read_backpressure();
        heartbeat_toggle();
        key_reset_cycle();
        $display("tests run %0d, failed %0d, checks failed %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/board_top.sv
/*
 * Board top: reset conditioner, heartbeat, AXI4-Lite port,
 * bus decoder, boot RAM, peripheral block, LED bank
 */
`timescale 1ns/1ns
`default_nettype none

module board_top import soc_bus_pkg::*, board_io_pkg::*; (
    input  logic         cpu_clk,
    input  logic         hard_rst_n,
    input  logic         key_rst_n_i,
    input  logic [9:0]   sw_i,
    input  axil_req_t    axil_req_i,
    output axil_rsp_t    axil_rsp_o,
    output board_leds_t  ledr_o,
    output hex_display_t hex_o
);

    logic       soc_rst_n;
    logic       heartbeat;
    logic [7:0] user_led;
    bus_req_t   port_req;
    bus_rsp_t   port_rsp;
    bus_req_t   ram_req;
    bus_rsp_t   ram_rsp;
    bus_req_t   pio_req;
    bus_rsp_t   pio_rsp;

    // ====================
    // Reset and heartbeat
    // ====================
    rst_conditioner i_rst_cond (
        .cpu_clk     (cpu_clk),
        .hard_rst_n  (hard_rst_n),
        .key_rst_n_i (key_rst_n_i),
        .soc_rst_n_o (soc_rst_n)
    );

    heartbeat_gen i_heartbeat (
        .cpu_clk     (cpu_clk),
        .soc_rst_n_i (soc_rst_n),
        .heartbeat_o (heartbeat)
    );

    // ====================
    // Bus fabric
    // ====================
    axil_slave_port i_axil_port (
        .cpu_clk     (cpu_clk),
        .soc_rst_n_i (soc_rst_n),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .bus_req_o   (port_req),
        .bus_rsp_i   (port_rsp)
    );

    bus_interconnect i_bus_ic (
        .cpu_clk     (cpu_clk),
        .soc_rst_n_i (soc_rst_n),
        .bus_req_i   (port_req),
        .bus_rsp_o   (port_rsp),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp),
        .pio_req_o   (pio_req),
        .pio_rsp_i   (pio_rsp)
    );

    boot_ram i_boot_ram (
        .cpu_clk     (cpu_clk),
        .soc_rst_n_i (soc_rst_n),
        .req_i       (ram_req),
        .rsp_o       (ram_rsp)
    );

    board_pio i_board_pio (
        .cpu_clk     (cpu_clk),
        .soc_rst_n_i (soc_rst_n),
        .req_i       (pio_req),
        .rsp_o       (pio_rsp),
        .sw_i        (sw_i),
        .user_led_o  (user_led),
        .hex_o       (hex_o)
    );

    // LED bank, reset indicator lit while the SoC is held
    assign ledr_o.heartbeat = heartbeat;
    assign ledr_o.in_reset  = ~soc_rst_n;
    assign ledr_o.user      = user_led;

endmodule

`default_nettype wire

// File: source/board_pio.sv
/*
 * Board peripheral block: LED and display registers,
 * switch readback, platform ID registers
 */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module board_pio import soc_bus_pkg::*, board_io_pkg::*; (
    input  logic         cpu_clk,
    input  logic         soc_rst_n_i,
    input  bus_req_t     req_i,
    output bus_rsp_t     rsp_o,
    input  logic [9:0]   sw_i,
    output logic [7:0]   user_led_o,
    output hex_display_t hex_o
);

    localparam int sel_hi = $clog2(`BRD_PIO_SPAN) - 1;

    logic [sel_hi-2:0] reg_sel;
    logic [7:0]        led_q;
    logic [15:0]       hex10_q;
    logic [15:0]       hex32_q;
    logic [15:0]       hex54_q;
    logic [31:0]       rd_mux;
    logic [31:0]       rdata_q;
    logic              ack_q;
    logic [15:0]       hex_wr;

    assign reg_sel = req_i.addr[sel_hi:2];

    // Byte-lane merge for the 16-bit digit pairs
    assign hex_wr[7:0]  = req_i.strb[0] ? req_i.wdata[7:0] : 8'h00;
    assign hex_wr[15:8] = req_i.strb[1] ? req_i.wdata[15:8] : 8'h00;

    // ====================
    // Writable registers
    // ====================
    always_ff @(posedge cpu_clk or negedge soc_rst_n_i) begin
        if (!soc_rst_n_i) begin
            led_q   <= '0;
            hex10_q <= '0;
            hex32_q <= '0;
            hex54_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= req_i.valid;
            if (req_i.valid && req_i.write) begin
                // Offsets 4 to 7 are read-only and drop the write
                case (reg_sel)
                    3'd0: if (req_i.strb[0]) led_q <= req_i.wdata[7:0];
                    3'd1: hex10_q <= hex_wr | (hex10_q & ~{{8{req_i.strb[1]}}, {8{req_i.strb[0]}}});
                    3'd2: hex32_q <= hex_wr | (hex32_q & ~{{8{req_i.strb[1]}}, {8{req_i.strb[0]}}});
                    3'd3: hex54_q <= hex_wr | (hex54_q & ~{{8{req_i.strb[1]}}, {8{req_i.strb[0]}}});
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (reg_sel)
            3'd0:    rd_mux = {24'd0, led_q};
            3'd1:    rd_mux = {16'd0, hex10_q};
            3'd2:    rd_mux = {16'd0, hex32_q};
            3'd3:    rd_mux = {16'd0, hex54_q};
            3'd4:    rd_mux = {22'd0, sw_i};
            3'd5:    rd_mux = `BRD_SOC_ID;
            3'd6:    rd_mux = `BRD_BLD_ID;
            default: rd_mux = `BRD_CORE_CLK_FREQ;
        endcase
    end

    always_ff @(posedge cpu_clk) begin
        if (req_i.valid && !req_i.write) begin
            rdata_q <= rd_mux;
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;
    assign user_led_o  = led_q;
    assign hex_o       = {hex54_q, hex32_q, hex10_q};

endmodule

`default_nettype wire

// File: source/boot_ram.sv
/* Word-addressed boot RAM with byte strobes */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module boot_ram import soc_bus_pkg::*; (
    input  logic     cpu_clk,
    input  logic     soc_rst_n_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    localparam int words = `BRD_RAM_WORDS;
    localparam int aw    = $clog2(words);

    logic [31:0]   mem [words];
    logic [aw-1:0] word_idx;
    logic [31:0]   rdata_q;
    logic          ack_q;

    assign word_idx = req_i.addr[aw+1:2];

    always_ff @(posedge cpu_clk) begin
        if (req_i.valid && req_i.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.strb[b]) begin
                    mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
        if (req_i.valid && !req_i.write) begin
            rdata_q <= mem[word_idx];
        end
    end

    always_ff @(posedge cpu_clk or negedge soc_rst_n_i) begin
        if (!soc_rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.valid;
        end
    end

    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;
    assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/bus_interconnect.sv
/*
 * Address decoder for boot RAM and peripheral windows,
 * error ack for unmapped addresses, response merge
 */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module bus_interconnect import soc_bus_pkg::*; (
    input  logic     cpu_clk,
    input  logic     soc_rst_n_i,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,
    output bus_req_t ram_req_o,
    input  bus_rsp_t ram_rsp_i,
    output bus_req_t pio_req_o,
    input  bus_rsp_t pio_rsp_i
);

    localparam logic [31:0] ram_bytes = 32'(`BRD_RAM_WORDS * 4);
    localparam logic [31:0] pio_bytes = 32'(`BRD_PIO_SPAN);

    logic [31:0] ram_off;
    logic [31:0] pio_off;
    logic        ram_hit;
    logic        pio_hit;
    logic        err_ack_q;

    // Offset compare works for any window base
    assign ram_off = bus_req_i.addr - `BRD_RAM_BASE;
    assign pio_off = bus_req_i.addr - `BRD_PIO_BASE;
    assign ram_hit = (ram_off < ram_bytes);
    assign pio_hit = (pio_off < pio_bytes);

    always_comb begin
        ram_req_o       = bus_req_i;
        ram_req_o.valid = bus_req_i.valid & ram_hit;
        pio_req_o       = bus_req_i;
        pio_req_o.valid = bus_req_i.valid & pio_hit;
    end

    always_ff @(posedge cpu_clk or negedge soc_rst_n_i) begin
        if (!soc_rst_n_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= bus_req_i.valid & ~ram_hit & ~pio_hit;
        end
    end

    // Only one responder is active, so OR is enough
    assign bus_rsp_o.ack   = ram_rsp_i.ack | pio_rsp_i.ack | err_ack_q;
    assign bus_rsp_o.err   = ram_rsp_i.err | pio_rsp_i.err | err_ack_q;
    assign bus_rsp_o.rdata = ({32{ram_rsp_i.ack}} & ram_rsp_i.rdata)
                           | ({32{pio_rsp_i.ack}} & pio_rsp_i.rdata);

endmodule

`default_nettype wire

// File: source/axil_slave_port.sv
/*
 * AXI4-Lite slave port, one transaction at a time,
 * converted into a single internal bus request
 */
`timescale 1ns/1ns
`default_nettype none

module axil_slave_port import soc_bus_pkg::*; (
    input  logic      cpu_clk,
    input  logic      soc_rst_n_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output bus_req_t  bus_req_o,
    input  bus_rsp_t  bus_rsp_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_respond
    } port_state_t;

    port_state_t state_q;
    logic        is_write_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  strb_q;
    logic [1:0]  resp_q;
    logic [31:0] rdata_q;
    logic        wr_pending;
    logic        rsp_taken;

    assign wr_pending = axil_req_i.awvalid & axil_req_i.wvalid;
    assign rsp_taken  = is_write_q ? axil_req_i.bready : axil_req_i.rready;

    // ====================
    // FSM
    // ====================
    always_ff @(posedge cpu_clk or negedge soc_rst_n_i) begin
        if (!soc_rst_n_i) begin
            state_q    <= st_idle;
            is_write_q <= 1'b0;
        end else begin
            case (state_q)
                st_idle: begin
                    // Write wins when both are pending
                    if (wr_pending) begin
                        is_write_q <= 1'b1;
                        state_q    <= st_issue;
                    end else if (axil_req_i.arvalid) begin
                        is_write_q <= 1'b0;
                        state_q    <= st_issue;
                    end
                end
                st_issue:   state_q <= st_wait;
                st_wait:    if (bus_rsp_i.ack) state_q <= st_respond;
                st_respond: if (rsp_taken) state_q <= st_idle;
                default:    state_q <= st_idle;
            endcase
        end
    end

    // Request capture while idle, response capture on ack
    always_ff @(posedge cpu_clk) begin
        if (state_q == st_idle) begin
            addr_q  <= wr_pending ? axil_req_i.awaddr : axil_req_i.araddr;
            wdata_q <= wr_pending ? axil_req_i.wdata : '0;
            strb_q  <= wr_pending ? axil_req_i.wstrb : '0;
        end
        if (state_q == st_wait && bus_rsp_i.ack) begin
            resp_q  <= bus_rsp_i.err ? resp_slverr : resp_okay;
            rdata_q <= bus_rsp_i.rdata;
        end
    end

    // Handshake accepted in the issue cycle, same cycle as the bus request
    always_comb begin
        axil_rsp_o.awready = (state_q == st_issue) & is_write_q;
        axil_rsp_o.wready  = (state_q == st_issue) & is_write_q;
        axil_rsp_o.arready = (state_q == st_issue) & ~is_write_q;
        axil_rsp_o.bvalid  = (state_q == st_respond) & is_write_q;
        axil_rsp_o.bresp   = resp_q;
        axil_rsp_o.rvalid  = (state_q == st_respond) & ~is_write_q;
        axil_rsp_o.rresp   = resp_q;
        axil_rsp_o.rdata   = rdata_q;
    end

    always_comb begin
        bus_req_o.valid = (state_q == st_issue);
        bus_req_o.write = is_write_q;
        bus_req_o.addr  = addr_q;
        bus_req_o.wdata = wdata_q;
        bus_req_o.strb  = strb_q;
    end

endmodule

`default_nettype wire

// File: source/heartbeat_gen.sv
/* Heartbeat tick down-counter and toggling flag */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module heartbeat_gen (
    input  logic cpu_clk,
    input  logic soc_rst_n_i,
    output logic heartbeat_o
);

    localparam int ticks = `BRD_HEARTBEAT_TICKS;
    localparam int cnt_w = $clog2(ticks + 1);

    logic [cnt_w-1:0] tick_cnt_q;
    logic             tick_q;

    always_ff @(posedge cpu_clk or negedge soc_rst_n_i) begin
        if (!soc_rst_n_i) begin
            tick_cnt_q  <= cnt_w'(ticks);
            tick_q      <= 1'b0;
            heartbeat_o <= 1'b0;
        end else begin
            tick_q <= (tick_cnt_q == '0);
            if (tick_cnt_q == '0) begin
                tick_cnt_q <= cnt_w'(ticks);
            end else begin
                tick_cnt_q <= tick_cnt_q - 1'b1;
            end
            if (tick_q) begin
                heartbeat_o <= ~heartbeat_o;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/rst_conditioner.sv
/*
 * Reset key synchroniser and release hold counter
 */
`timescale 1ns/1ns
`default_nettype none
`include "board_config.svh"

module rst_conditioner (
    input  logic cpu_clk,
    input  logic hard_rst_n,
    input  logic key_rst_n_i,
    output logic soc_rst_n_o
);

    localparam int hold_cycles = `BRD_RST_HOLD_CYCLES;
    localparam int cnt_w       = $clog2(hold_cycles);

    logic [1:0]       key_sync_q;
    logic [cnt_w-1:0] hold_cnt_q;
    logic             released_q;

    always_ff @(posedge cpu_clk or negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            key_sync_q <= '0;
            hold_cnt_q <= '0;
            released_q <= 1'b0;
        end else begin
            key_sync_q <= {key_sync_q[0], key_rst_n_i};
            if (!key_sync_q[1]) begin
                // Any low sample restarts the quiet window
                hold_cnt_q <= '0;
                released_q <= 1'b0;
            end else if (!released_q) begin
                if (hold_cnt_q == cnt_w'(hold_cycles - 1)) begin
                    released_q <= 1'b1;
                end else begin
                    hold_cnt_q <= hold_cnt_q + 1'b1;
                end
            end
        end
    end

    // Assert straight from the synchroniser, release through the counter
    assign soc_rst_n_o = released_q & key_sync_q[1];

endmodule

`default_nettype wire

// File: source/board_io_pkg.sv
/* LED bank and seven-segment display structs */
`default_nettype none

package board_io_pkg;

    // Bit 9 heartbeat, bit 8 reset indicator, bits 7:0 user
    typedef struct packed {
        logic       heartbeat;
        logic       in_reset;
        logic [7:0] user;
    } board_leds_t;

    typedef struct packed {
        logic [7:0] hex5;
        logic [7:0] hex4;
        logic [7:0] hex3;
        logic [7:0] hex2;
        logic [7:0] hex1;
        logic [7:0] hex0;
    } hex_display_t;

endpackage

`default_nettype wire

// File: source/soc_bus_pkg.sv
/*
 * AXI4-Lite channel structs, internal bus request and
 * response structs, AXI response codes
 */
`default_nettype none

package soc_bus_pkg;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // ====================
    // AXI4-Lite
    // ====================
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // Internal single-transaction bus
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } bus_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: include/board_config.svh
/*
 * Board address map, platform ID values, boot RAM depth,
 * heartbeat reload count and reset release hold count
 */
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ====================
// Address map
// ====================
`define BRD_RAM_BASE        32'h0000_0000
`define BRD_RAM_WORDS       256
`define BRD_PIO_BASE        32'h0001_0000
`define BRD_PIO_SPAN        32

// Platform ID registers
`define BRD_SOC_ID          32'h5C10_0A01
`define BRD_BLD_ID          32'h0000_0107
`define BRD_CORE_CLK_FREQ   32'd50_000_000

// Short heartbeat period for simulation
`define BRD_HEARTBEAT_TICKS 50
`define BRD_RST_HOLD_CYCLES 16

`endif
